// ==== dispatch_pkg.sv ====
`default_nettype none

package dispatch_pkg;

    // datapath widths
    localparam int xlen       = 32;
    localparam int reg_idx_w  = 5;
    localparam int excp_w     = 16;
    localparam int op_class_w = 4;

    // operation classes carried in the decoded instruction
    localparam logic [op_class_w-1:0] op_alu        = 4'd0;
    localparam logic [op_class_w-1:0] op_br         = 4'd1;
    localparam logic [op_class_w-1:0] op_div        = 4'd2;
    localparam logic [op_class_w-1:0] op_priv       = 4'd3;
    localparam logic [op_class_w-1:0] op_mul        = 4'd4;
    localparam logic [op_class_w-1:0] op_load_store = 4'd5;
    localparam logic [op_class_w-1:0] op_priv_mem   = 4'd6;
    localparam logic [op_class_w-1:0] op_rdcnt      = 4'd7;
    localparam logic [op_class_w-1:0] op_alu_br     = 4'd8;
    localparam logic [op_class_w-1:0] op_ibar       = 4'd9;
    localparam logic [op_class_w-1:0] op_priv_mmu   = 4'd10;
    localparam logic [op_class_w-1:0] op_mmu        = 4'd11;

    // one decoded instruction
    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       ir;
        logic [xlen-1:0]       imm;
        logic [reg_idx_w-1:0]  rd;
        logic [reg_idx_w-1:0]  rj;
        logic [reg_idx_w-1:0]  rk;
        logic [op_class_w-1:0] op_class;
        logic                  reg_write;
        logic [excp_w-1:0]     excp_arg;
    } inst_t;

    // decoded pair in program order
    // younger_valid low marks a lone instruction at the end of a group
    typedef struct packed {
        inst_t older;
        inst_t younger;
        logic  older_valid;
        logic  younger_valid;
    } inst_pair_t;

    // what goes to the two execution lanes
    typedef struct packed {
        inst_t full;
        inst_t arith;
        logic  full_valid;
        logic  arith_valid;
    } issue_pair_t;

endpackage

`default_nettype wire

// ==== dispatch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch_top
    import dispatch_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        flush,
    input  inst_pair_t  in_pair,
    input  logic        in_valid,
    output logic        in_ready,
    output issue_pair_t issue_out,
    output logic        issue_valid,
    input  logic        issue_ready
);

    // input stage to dispatcher
    inst_pair_t stage_pair;
    logic       stage_valid;
    logic       stage_ready;

    // dispatcher to output stage
    issue_pair_t disp_issue;
    logic        disp_valid;
    logic        disp_ready;

    // scoreboard link
    logic                 sb_advance;
    logic                 full_issued;
    logic                 arith_issued;
    logic                 full_multi;
    logic                 arith_multi;
    logic [reg_idx_w-1:0] full_rd;
    logic [reg_idx_w-1:0] arith_rd;
    logic [reg_idx_w-1:0] pend_full_rd;
    logic [reg_idx_w-1:0] pend_arith_rd;
    logic                 pend_full;
    logic                 pend_arith;

    pipe_stage #(
        .payload_t (inst_pair_t)
    ) u_in_stage (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (flush),
        .in_data   (in_pair),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (stage_pair),
        .out_valid (stage_valid),
        .out_ready (stage_ready)
    );

    pair_dispatcher u_dispatcher (
        .clk           (clk),
        .rstn          (rstn),
        .flush         (flush),
        .pair          (stage_pair),
        .pair_valid    (stage_valid),
        .pair_ready    (stage_ready),
        .issue         (disp_issue),
        .issue_valid   (disp_valid),
        .issue_ready   (disp_ready),
        .pend_full_rd  (pend_full_rd),
        .pend_arith_rd (pend_arith_rd),
        .pend_full     (pend_full),
        .pend_arith    (pend_arith),
        .sb_advance    (sb_advance),
        .full_issued   (full_issued),
        .arith_issued  (arith_issued),
        .full_multi    (full_multi),
        .arith_multi   (arith_multi),
        .full_rd       (full_rd),
        .arith_rd      (arith_rd)
    );

    issue_scoreboard u_scoreboard (
        .clk           (clk),
        .rstn          (rstn),
        .flush         (flush),
        .advance       (sb_advance),
        .full_issued   (full_issued),
        .arith_issued  (arith_issued),
        .full_multi    (full_multi),
        .arith_multi   (arith_multi),
        .full_rd       (full_rd),
        .arith_rd      (arith_rd),
        .pend_full_rd  (pend_full_rd),
        .pend_arith_rd (pend_arith_rd),
        .pend_full     (pend_full),
        .pend_arith    (pend_arith)
    );

    pipe_stage #(
        .payload_t (issue_pair_t)
    ) u_out_stage (
        .clk       (clk),
        .rstn      (rstn),
        .flush     (flush),
        .in_data   (disp_issue),
        .in_valid  (disp_valid),
        .in_ready  (disp_ready),
        .out_data  (issue_out),
        .out_valid (issue_valid),
        .out_ready (issue_ready)
    );

endmodule

`default_nettype wire

// ==== issue_scoreboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_scoreboard
    import dispatch_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 flush,
    input  logic                 advance,
    input  logic                 full_issued,
    input  logic                 arith_issued,
    input  logic                 full_multi,
    input  logic                 arith_multi,
    input  logic [reg_idx_w-1:0] full_rd,
    input  logic [reg_idx_w-1:0] arith_rd,
    output logic [reg_idx_w-1:0] pend_full_rd,
    output logic [reg_idx_w-1:0] pend_arith_rd,
    output logic                 pend_full,
    output logic                 pend_arith
);

    // one entry per lane for the last issue cycle only
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pend_full  <= 1'b0;
            pend_arith <= 1'b0;
        end else if (flush) begin
            pend_full  <= 1'b0;
            pend_arith <= 1'b0;
        end else if (advance) begin
            // r0 is never a real destination
            pend_full  <= full_issued && full_multi && (full_rd != '0);
            pend_arith <= arith_issued && arith_multi && (arith_rd != '0);
        end
    end

    // destinations of the last issue cycle
    always_ff @(posedge clk) begin
        if (advance) begin
            pend_full_rd  <= full_rd;
            pend_arith_rd <= arith_rd;
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
dispatch_pkg.sv
pipe_stage.sv
issue_scoreboard.sv
pair_dispatcher.sv
dispatch_top.sv
+incdir+.
tb_dispatch.sv

// ==== pair_dispatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module pair_dispatcher
    import dispatch_pkg::*;
(
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 flush,
    input  inst_pair_t           pair,
    input  logic                 pair_valid,
    output logic                 pair_ready,
    output issue_pair_t          issue,
    output logic                 issue_valid,
    input  logic                 issue_ready,
    input  logic [reg_idx_w-1:0] pend_full_rd,
    input  logic [reg_idx_w-1:0] pend_arith_rd,
    input  logic                 pend_full,
    input  logic                 pend_arith,
    output logic                 sb_advance,
    output logic                 full_issued,
    output logic                 arith_issued,
    output logic                 full_multi,
    output logic                 arith_multi,
    output logic [reg_idx_w-1:0] full_rd,
    output logic [reg_idx_w-1:0] arith_rd
);

    // branches compare rd, so rd counts as a source for them
    function automatic logic is_branch(input logic [op_class_w-1:0] c);
        return (c == op_br) || (c == op_alu_br);
    endfunction

    // classes the arith lane can execute
    function automatic logic is_arith_class(input logic [op_class_w-1:0] c);
        return c inside {op_alu, op_br, op_div, op_mul, op_alu_br, op_ibar};
    endfunction

    // result not ready for an instruction issued next cycle
    function automatic logic is_multi(input inst_t i);
        return (i.op_class inside {op_mul, op_div, op_load_store}) ||
               ((i.op_class == op_priv) && i.reg_write);
    endfunction

    function automatic logic reads_reg(input inst_t i, input logic [reg_idx_w-1:0] r);
        return (i.rj == r) || (i.rk == r) || (is_branch(i.op_class) && (i.rd == r));
    endfunction

    logic  hold_q;
    inst_t cur_old;
    inst_t cur_young;
    logic  cur_old_v;
    logic  cur_young_v;
    logic  old_blocked;
    logic  young_blocked;
    logic  young_dep;
    logic  can_pair;
    logic  send_old;
    logic  last_inst;

    // after a split, or for a lone younger, the younger acts as the older
    always_comb begin
        if (hold_q || !pair.older_valid) begin
            cur_old   = pair.younger;
            cur_old_v = pair.younger_valid;
        end else begin
            cur_old   = pair.older;
            cur_old_v = 1'b1;
        end
        cur_young   = pair.younger;
        cur_young_v = !hold_q && pair.older_valid && pair.younger_valid;
    end

    // scoreboard hits
    assign old_blocked   = (pend_full && reads_reg(cur_old, pend_full_rd)) ||
                           (pend_arith && reads_reg(cur_old, pend_arith_rd));
    assign young_blocked = (pend_full && reads_reg(cur_young, pend_full_rd)) ||
                           (pend_arith && reads_reg(cur_young, pend_arith_rd));

    // younger reads what the older writes
    assign young_dep = cur_old.reg_write && (cur_old.rd != '0) &&
                       reads_reg(cur_young, cur_old.rd);

    assign can_pair  = cur_young_v && is_arith_class(cur_young.op_class) &&
                       !young_dep && !young_blocked;
    assign send_old  = pair_valid && cur_old_v && !old_blocked;
    assign last_inst = !cur_young_v || can_pair;

    // unused lanes stay all zero
    always_comb begin
        issue = '0;
        if (send_old) begin
            issue.full       = cur_old;
            issue.full_valid = 1'b1;
            if (can_pair) begin
                issue.arith       = cur_young;
                issue.arith_valid = 1'b1;
            end
        end
    end

    assign issue_valid = issue.full_valid;

    // release the pair only with its last instruction, or drop an empty one
    assign pair_ready = issue_ready && (send_old ? last_inst : !cur_old_v);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hold_q <= 1'b0;
        end else if (flush) begin
            hold_q <= 1'b0;
        end else if (send_old && issue_ready) begin
            hold_q <= !last_inst;
        end
    end

    // scoreboard follows the output stage
    assign sb_advance   = issue_ready;
    assign full_issued  = issue.full_valid;
    assign arith_issued = issue.arith_valid;
    assign full_multi   = is_multi(issue.full);
    assign arith_multi  = is_multi(issue.arith);
    assign full_rd      = issue.full.rd;
    assign arith_rd     = issue.arith.rd;

    a_arith_class: assert property (
        @(posedge clk) disable iff (!rstn)
            issue.arith_valid |-> is_arith_class(issue.arith.op_class))
        else $error("pair_dispatcher: arith lane got a non-arith class");

    a_arith_needs_full: assert property (
        @(posedge clk) disable iff (!rstn)
            $rose(issue.arith_valid) |-> issue.full_valid)
        else $error("pair_dispatcher: arith lane issued without full lane");

endmodule

`default_nettype wire

// ==== pipe_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rstn,
    input  logic     flush,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    logic     valid_q;
    payload_t data_q;

    // empty, or the current entry leaves on this edge
    assign in_ready  = !valid_q || out_ready;
    assign out_valid = valid_q;
    assign out_data  = data_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // payload only moves on a handshake
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    // a stalled entry must not change under the consumer
    property p_hold_when_stalled;
        @(posedge clk) disable iff (!rstn || flush)
            out_valid && !out_ready |=> $stable(out_data) && out_valid;
    endproperty

    a_hold_when_stalled: assert property (p_hold_when_stalled)
        else $error("pipe_stage: output changed while stalled");

endmodule

`default_nettype wire

// ==== tb_dispatch_checks.svh ====
`ifndef TB_DISPATCH_CHECKS_SVH
`define TB_DISPATCH_CHECKS_SVH

// one lane's instruction with all of its fields
task automatic compare_inst(input string name, input inst_t got, input inst_t exp);
    if (got !== exp) begin
        errors++;
        $display("ERROR %s: got %h expected %h", name, got, exp);
    end
endtask

// both lanes and their valid bits
task automatic compare_issue_pair(input string name, input issue_pair_t got,
                                  input issue_pair_t exp);
    compare_inst({name, ".full"}, got.full, exp.full);
    compare_inst({name, ".arith"}, got.arith, exp.arith);
    if ({got.full_valid, got.arith_valid} !== {exp.full_valid, exp.arith_valid}) begin
        errors++;
        $display("ERROR %s.valid: got %h expected %h", name,
                 {got.full_valid, got.arith_valid}, {exp.full_valid, exp.arith_valid});
    end
endtask

`endif

// ==== tb_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dispatch
    import dispatch_pkg::*;
;

    // rough cycle cost of each test in order
    localparam int test_cycles = 30 + 40 + 40 + 40 + 120 + 400;

    logic        clk = 1'b0;
    logic        rstn;
    logic        flush;
    inst_pair_t  in_pair;
    logic        in_valid;
    logic        in_ready;
    issue_pair_t issue_out;
    logic        issue_valid;
    logic        issue_ready;

    int          errors = 0;
    int          npass = 0;
    int          nfail = 0;
    int          cycle = 0;
    int          ready_mode = 0;
    logic [31:0] seed = 32'hf36c_b773;
    logic [31:0] ready_seed = ~32'hf36c_b773;
    logic [31:0] pc_next = 32'h0000_1000;
    inst_pair_t  drive_q[$];
    inst_pair_t  stim_q[$];
    issue_pair_t exp_q[$];
    issue_pair_t log_q[$];
    issue_pair_t held;
    logic        was_stalled = 1'b0;
    int          acc_cyc[$];
    int          log_cyc[$];
    // model copy of the pending destinations
    logic [reg_idx_w-1:0] m_rd[2];
    logic                 m_pv[2];

    `include "tb_dispatch_checks.svh"

    dispatch_top dut0 (
        .clk         (clk),
        .rstn        (rstn),
        .flush       (flush),
        .in_pair     (in_pair),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .issue_out   (issue_out),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready)
    );

    always #20 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // keeps in_valid up while pairs are queued
    always @(posedge clk) begin
        if (in_valid && in_ready && drive_q.size() > 0) begin
            void'(drive_q.pop_front());
            acc_cyc.push_back(cycle);
        end
        in_valid <= (drive_q.size() > 0);
        if (drive_q.size() > 0)
            in_pair <= drive_q[0];
    end

    always @(posedge clk) begin
        ready_seed = xorshift(ready_seed);
        case (ready_mode)
            0: issue_ready <= 1'b1;
            1: issue_ready <= ready_seed[3] | ready_seed[9];
            default: issue_ready <= 1'b0;
        endcase
    end

    // log every accepted issue and check stability under back-pressure
    always @(posedge clk) begin
        if (rstn && issue_valid && issue_ready) begin
            log_q.push_back(issue_out);
            log_cyc.push_back(cycle);
        end
        if (rstn && was_stalled && issue_valid)
            compare_issue_pair("issue_out", issue_out, held);
        was_stalled <= issue_valid && !issue_ready && !flush;
        held        <= issue_out;
    end

    initial begin
        #(test_cycles * 4 * 40);
        $display("watchdog expired before the tests completed");
        $display("=== FAIL ===");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic inst_t make_inst(input logic [3:0] cls, input logic [4:0] rd,
                                        input logic [4:0] rj, input logic [4:0] rk,
                                        input logic wr);
        inst_t i;
        seed       = xorshift(seed);
        i.pc       = pc_next;
        pc_next    = pc_next + 4;
        i.ir       = seed;
        i.imm      = {seed[15:0], seed[31:16]};
        i.rd       = rd;
        i.rj       = rj;
        i.rk       = rk;
        i.op_class = cls;
        i.reg_write = wr;
        i.excp_arg = seed[23:8];
        return i;
    endfunction

    function automatic inst_pair_t make_pair(input inst_t o, input inst_t y, input logic yv);
        inst_pair_t p;
        p.older         = o;
        p.younger       = y;
        p.older_valid   = 1'b1;
        p.younger_valid = yv;
        return p;
    endfunction

    function automatic inst_pair_t random_pair();
        inst_t o;
        inst_t y;
        seed = xorshift(seed);
        o = make_inst(seed[3:0] % 12, seed[6:4], seed[9:7], seed[12:10], seed[13]);
        seed = xorshift(seed);
        y = make_inst(seed[3:0] % 12, seed[6:4], seed[9:7], seed[12:10], seed[13]);
        return make_pair(o, y, seed[18:16] != 0);
    endfunction

    // reads r as a source; branches compare rd too
    function automatic logic uses(input inst_t i, input logic [4:0] r);
        return i.rj == r || i.rk == r ||
               ((i.op_class == op_br || i.op_class == op_alu_br) && i.rd == r);
    endfunction

    function automatic logic sb_hit(input inst_t i);
        return (m_pv[0] && uses(i, m_rd[0])) || (m_pv[1] && uses(i, m_rd[1]));
    endfunction

    function automatic logic multi_cycle(input inst_t i);
        return i.op_class == op_mul || i.op_class == op_div ||
               i.op_class == op_load_store || (i.op_class == op_priv && i.reg_write);
    endfunction

    function automatic logic arith_ok(input logic [3:0] c);
        return c == op_alu || c == op_br || c == op_div || c == op_mul ||
               c == op_alu_br || c == op_ibar;
    endfunction

    // expected issue groups of one pair with the model scoreboard kept up to date
    task automatic predict(input inst_pair_t p);
        inst_t       q[$];
        issue_pair_t g;
        int          k;
        if (p.older_valid)
            q.push_back(p.older);
        if (p.younger_valid)
            q.push_back(p.younger);
        k = 0;
        while (k < q.size()) begin
            if (sb_hit(q[k])) begin
                // bubble
                m_pv[0] = 1'b0;
                m_pv[1] = 1'b0;
            end else begin
                g = '0;
                g.full = q[k];
                g.full_valid = 1'b1;
                k++;
                if (k == 1 && q.size() == 2 && arith_ok(q[1].op_class) && !sb_hit(q[1]) &&
                    !(q[0].reg_write && q[0].rd != 0 && uses(q[1], q[0].rd))) begin
                    g.arith = q[1];
                    g.arith_valid = 1'b1;
                    k++;
                end
                m_pv[0] = multi_cycle(g.full) && g.full.rd != 0;
                m_rd[0] = g.full.rd;
                m_pv[1] = g.arith_valid && multi_cycle(g.arith) && g.arith.rd != 0;
                m_rd[1] = g.arith.rd;
                exp_q.push_back(g);
            end
        end
    endtask

    // drive stim_q, wait for every predicted group, then compare in order
    task automatic run_stream();
        m_pv[0] = 1'b0;
        m_pv[1] = 1'b0;
        exp_q.delete();
        foreach (stim_q[i])
            predict(stim_q[i]);
        @(negedge clk);
        log_q.delete();
        log_cyc.delete();
        acc_cyc.delete();
        foreach (stim_q[i])
            drive_q.push_back(stim_q[i]);
        stim_q.delete();
        while (drive_q.size() > 0 || log_q.size() < exp_q.size())
            @(negedge clk);
        repeat (6) @(negedge clk);
        if (log_q.size() != exp_q.size()) begin
            errors++;
            $display("ERROR got %0d issues but expected %0d", log_q.size(), exp_q.size());
        end
        foreach (exp_q[i])
            compare_issue_pair($sformatf("issue[%0d]", i), log_q[i], exp_q[i]);
    endtask

    task automatic check_gap(input int a, input int b, input int gap);
        if (log_cyc.size() <= b || log_cyc[b] - log_cyc[a] != gap) begin
            errors++;
            $display("ERROR issues %0d and %0d are not %0d cycles apart", a, b, gap);
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before) begin
            npass++;
            $display("%s: ok", name);
        end else begin
            nfail++;
            $display("%s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic independent_pair();
        int e;
        e = errors;
        // idle state after reset
        @(negedge clk);
        if (in_ready !== 1'b1 || issue_valid !== 1'b0) begin
            errors++;
            $display("ERROR in_ready/issue_valid after reset: got %h/%h expected 1/0",
                     in_ready, issue_valid);
        end
        stim_q.push_back(make_pair(make_inst(op_alu, 1, 2, 3, 1),
                                   make_inst(op_alu, 4, 5, 6, 1), 1));
        run_stream();
        if (acc_cyc.size() == 0 || log_cyc.size() == 0 || log_cyc[0] - acc_cyc[0] != 2) begin
            errors++;
            $display("ERROR pair did not issue two cycles after acceptance");
        end
        finish_test("test 1 independent pair", e);
    endtask

    task automatic dependent_split();
        int e;
        e = errors;
        stim_q.push_back(make_pair(make_inst(op_alu, 7, 1, 2, 1),
                                   make_inst(op_alu, 8, 7, 3, 1), 1));
        stim_q.push_back(make_pair(make_inst(op_alu, 9, 1, 2, 1),
                                   make_inst(op_br, 9, 1, 2, 0), 1));
        run_stream();
        check_gap(0, 1, 1);
        finish_test("test 2 dependent split", e);
    endtask

    task automatic lane_split();
        int e;
        e = errors;
        stim_q.push_back(make_pair(make_inst(op_alu, 1, 2, 3, 1),
                                   make_inst(op_load_store, 4, 5, 6, 1), 1));
        stim_q.push_back(make_pair(make_inst(op_alu, 7, 2, 3, 1),
                                   make_inst(op_priv, 10, 11, 12, 0), 1));
        run_stream();
        finish_test("test 3 full-lane-only younger", e);
    endtask

    task automatic multi_bubble();
        int e;
        e = errors;
        stim_q.push_back(make_pair(make_inst(op_mul, 5, 1, 2, 1),
                                   make_inst(op_alu, 6, 1, 2, 1), 1));
        stim_q.push_back(make_pair(make_inst(op_alu, 8, 5, 1, 1),
                                   make_inst(op_alu, 10, 11, 12, 1), 1));
        stim_q.push_back(make_pair(make_inst(op_load_store, 0, 1, 2, 1),
                                   make_inst(op_alu, 13, 1, 2, 1), 1));
        stim_q.push_back(make_pair(make_inst(op_alu, 14, 0, 0, 1),
                                   make_inst(op_alu, 15, 1, 2, 1), 1));
        run_stream();
        check_gap(0, 1, 2);
        check_gap(2, 3, 1);
        finish_test("test 4 multi-cycle bubble", e);
    endtask

    task automatic stall_and_flush();
        int e;
        e = errors;
        ready_mode = 1;
        repeat (8) stim_q.push_back(random_pair());
        run_stream();
        // stall the output so the younger half stays held, then flush
        ready_mode = 2;
        drive_q.push_back(make_pair(make_inst(op_alu, 3, 1, 2, 1),
                                    make_inst(op_alu, 4, 3, 1, 1), 1));
        repeat (2) drive_q.push_back(random_pair());
        log_q.delete();
        while (!issue_valid)
            @(negedge clk);
        @(posedge clk);
        flush <= 1'b1;
        @(negedge clk);
        drive_q.delete();
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        ready_mode = 0;
        repeat (8) @(negedge clk);
        if (log_q.size() != 0) begin
            errors++;
            $display("ERROR %0d instructions issued after the flush", log_q.size());
        end
        stim_q.push_back(make_pair(make_inst(op_alu, 1, 2, 3, 1),
                                   make_inst(op_alu, 4, 5, 6, 1), 1));
        run_stream();
        finish_test("test 5 back-pressure and flush", e);
    endtask

    task automatic random_stream();
        int e;
        e = errors;
        ready_mode = 1;
        repeat (40) stim_q.push_back(random_pair());
        run_stream();
        ready_mode = 0;
        finish_test("test 6 random stream", e);
    endtask

    initial begin
        rstn        <= 1'b0;
        flush       <= 1'b0;
        in_valid    <= 1'b0;
        in_pair     <= '0;
        issue_ready <= 1'b1;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        repeat (2) @(posedge clk);
        independent_pair();
        dependent_split();
        lane_split();
        multi_bubble();
        stall_and_flush();
        random_stream();
        $display("tests passed %0d failed %0d", npass, nfail);
        if (nfail == 0 && errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
